/* hdl/selftest_pkg.sv */
/*
 * Shared sizes, state and opcode enums, memory request and status structs
 * for the power-on self-test block
 */

package selftest_pkg;

   // Memory geometry
   localparam int ADDR_W    = 4;
   localparam int DATA_W    = 8;
   localparam int MEM_WORDS = 2 ** ADDR_W;

   // Clock-ratio check, window in clk cycles
   localparam int CLK_WINDOW = 64;
   // fastclk cycles per clk cycle
   localparam int FAST_RATIO = 4;
   // Allowed edge-count deviation
   localparam int RATIO_TOL  = 8;
   // Gray counter and difference width
   localparam int CNT_W      = 12;

   // Sequencer FSM
   typedef enum logic [2:0] {
      ST_IDLE,
      ST_MEM,
      ST_CLK_ARM,
      ST_CLK_RUN,
      ST_DONE
   } seq_state_e;

   // March elements, in execution order
   typedef enum logic [1:0] {
      OP_W0_UP,
      OP_R0W1_UP,
      OP_R1W0_DOWN,
      OP_R0_UP
   } march_op_e;

   // Result codes
   typedef enum logic [1:0] {
      RES_NONE,
      RES_MEM,
      RES_CLK
   } fail_code_e;

   // Synchronous memory request
   typedef struct packed {
      logic              en;
      logic              we;
      logic [ADDR_W-1:0] addr;
      logic [DATA_W-1:0] wdata;
   } mem_req_t;

   // Status seen by the rest of the chip
   typedef struct packed {
      logic              busy;
      logic              done;
      logic              passed;
      fail_code_e        fail_code;
      logic [ADDR_W-1:0] fail_addr;
   } selftest_status_t;

endpackage

/* hdl/cycle_timer.sv */
/*
 * Window timer for the clock-ratio check
 * Counts CLK_WINDOW cycles after load, then pulses expire
 */
`timescale 1ns/10ps

module cycle_timer
   import selftest_pkg::*;
(
   input  logic clk,
   input  logic arst_n,
   input  logic load,
   output logic expire,
   output logic running
);

   logic [$clog2(CLK_WINDOW)-1:0] cnt;

   // Zero count while running is the last window cycle
   assign expire = running && (cnt == '0);

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         cnt     <= '0;
         running <= 1'b0;
      end else if (load) begin
         cnt     <= $bits(cnt)'(CLK_WINDOW - 1);
         running <= 1'b1;
      end else if (running) begin
         if (cnt == '0) begin
            running <= 1'b0;
         end else begin
            cnt <= cnt - 1'b1;
         end
      end
   end

   // Sequencer reloads only after the window closed
   a_no_reload: assert property (@(posedge clk) disable iff (!arst_n) running |-> !load);

endmodule

/* hdl/march_check.sv */
/*
 * March test engine over an external synchronous memory
 * All-zeros / all-ones elements, first failing address capture
 */
`timescale 1ns/10ps

module march_check
   import selftest_pkg::*;
(
   input  logic              clk,
   input  logic              arst_n,
   input  logic              start,
   output mem_req_t          mem_req,
   input  logic [DATA_W-1:0] mem_rdata,
   output logic              done,
   output logic              ok,
   output logic [ADDR_W-1:0] fail_addr
);

   march_op_e         op;
   logic              active;
   // 0 = read half, 1 = write half of a read-then-write element
   logic              phase;
   logic [ADDR_W-1:0] addr;
   logic              is_read;
   logic              at_top;
   logic              at_bot;
   // Outstanding read, compared in the data cycle
   logic              rd_pend;
   logic              rd_last;
   logic              rd_exp_one;
   logic [ADDR_W-1:0] rd_addr;
   logic              mismatch;

   assign is_read  = active && (op != OP_W0_UP) && !phase;
   assign at_top   = (addr == ADDR_W'(MEM_WORDS - 1));
   assign at_bot   = (addr == '0);
   assign mismatch = rd_pend && (mem_rdata != {DATA_W{rd_exp_one}});

   always_comb begin
      mem_req.en    = active;
      mem_req.we    = active && !is_read;
      mem_req.addr  = addr;
      // Only the ascending read/write element writes ones
      mem_req.wdata = (op == OP_R0W1_UP) ? '1 : '0;
   end

   // Element and address walk
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         active <= 1'b0;
         op     <= OP_W0_UP;
         phase  <= 1'b0;
         addr   <= '0;
      end else if (start) begin
         active <= 1'b1;
         op     <= OP_W0_UP;
         phase  <= 1'b0;
         addr   <= '0;
      end else if (mismatch) begin
         // Abort on first fault
         active <= 1'b0;
      end else if (active) begin
         case (op)
            OP_W0_UP: begin
               if (at_top) op <= OP_R0W1_UP;
               addr <= addr + 1'b1;
            end
            OP_R0W1_UP: begin
               phase <= !phase;
               if (phase) begin
                  if (at_top) op <= OP_R1W0_DOWN;
                  else addr <= addr + 1'b1;
               end
            end
            OP_R1W0_DOWN: begin
               phase <= !phase;
               if (phase) begin
                  if (at_bot) op <= OP_R0_UP;
                  else addr <= addr - 1'b1;
               end
            end
            default: begin
               if (at_top) active <= 1'b0;
               addr <= addr + 1'b1;
            end
         endcase
      end
   end

   // Read bookkeeping, no new compare once aborting
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         rd_pend <= 1'b0;
         rd_last <= 1'b0;
      end else begin
         rd_pend <= is_read && !mismatch;
         rd_last <= is_read && (op == OP_R0_UP) && at_top;
      end
   end

   always_ff @(posedge clk) begin
      if (is_read) begin
         rd_exp_one <= (op == OP_R1W0_DOWN);
         rd_addr    <= addr;
      end
      if (mismatch) fail_addr <= rd_addr;
   end

   // Result, ok valid with done
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         done <= 1'b0;
         ok   <= 1'b0;
      end else begin
         done <= mismatch || (rd_pend && rd_last);
         ok   <= !mismatch;
      end
   end

   // Memory released by the time a result is reported
   a_idle_no_access: assert property (@(posedge clk) disable iff (!arst_n)
      done |-> !mem_req.en);

endmodule

/* hdl/clk_ratio_check.sv */
/*
 * fastclk to clk ratio check
 * Gray counter on fastclk, 2-flop synchronizer, window count compare
 */
`timescale 1ns/10ps

module clk_ratio_check
   import selftest_pkg::*;
(
   input  logic clk,
   input  logic fastclk,
   input  logic arst_n,
   input  logic start,
   input  logic mark,
   output logic done,
   output logic ok
);

   logic [CNT_W-1:0] bin_f;
   logic [CNT_W-1:0] bin_f_nxt;
   logic [CNT_W-1:0] gray_f;
   logic [CNT_W-1:0] gray_s1;
   logic [CNT_W-1:0] gray_s2;
   logic [CNT_W-1:0] cur_bin;
   logic [CNT_W-1:0] first_bin;
   logic [CNT_W-1:0] diff;
   logic             have_first;
   logic             in_band;

   function automatic logic [CNT_W-1:0] gray2bin(input logic [CNT_W-1:0] g);
      logic [CNT_W-1:0] b;
      b[CNT_W-1] = g[CNT_W-1];
      for (int i = CNT_W - 2; i >= 0; i--) begin
         b[i] = b[i+1] ^ g[i];
      end
      return b;
   endfunction

   // fastclk domain, gray code registered so one bit moves per edge
   assign bin_f_nxt = bin_f + 1'b1;

   always_ff @(posedge fastclk or negedge arst_n) begin
      if (!arst_n) begin
         bin_f  <= '0;
         gray_f <= '0;
      end else begin
         bin_f  <= bin_f_nxt;
         gray_f <= bin_f_nxt ^ (bin_f_nxt >> 1);
      end
   end

   // Into clk, equal latency at both marks cancels in diff
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         gray_s1 <= '0;
         gray_s2 <= '0;
      end else begin
         gray_s1 <= gray_f;
         gray_s2 <= gray_s1;
      end
   end

   assign cur_bin = gray2bin(gray_s2);
   // Modulo difference, counter wraps harmlessly
   assign diff    = cur_bin - first_bin;
   assign in_band = (diff >= CNT_W'(CLK_WINDOW * FAST_RATIO - RATIO_TOL)) &&
                    (diff <= CNT_W'(CLK_WINDOW * FAST_RATIO + RATIO_TOL));

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         have_first <= 1'b0;
         done       <= 1'b0;
         ok         <= 1'b0;
      end else begin
         done <= 1'b0;
         if (start) begin
            have_first <= 1'b0;
         end else if (mark) begin
            // Second mark closes the window
            have_first <= !have_first;
            if (have_first) begin
               done <= 1'b1;
               ok   <= in_band;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (mark && !have_first) first_bin <= cur_bin;
   end

endmodule

/* hdl/selftest_seq.sv */
/*
 * Self-test sequencer FSM
 * Runs the march test, then the clock-ratio check, and builds the status
 */
`timescale 1ns/10ps

module selftest_seq
   import selftest_pkg::*;
(
   input  logic              clk,
   input  logic              arst_n,
   input  logic              start,
   input  logic              mem_done,
   input  logic              mem_ok,
   input  logic              clk_done,
   input  logic              clk_ok,
   input  logic              expire,
   input  logic [ADDR_W-1:0] fail_addr_in,
   output logic              mem_start,
   output logic              clk_start,
   output logic              clk_mark,
   output logic              timer_load,
   output selftest_status_t  status
);

   seq_state_e        state;
   fail_code_e        fail_code;
   logic              passed;
   logic [ADDR_W-1:0] fail_addr;

   // Strobes decoded from state
   assign mem_start  = (state == ST_IDLE) && start;
   assign clk_start  = (state == ST_MEM) && mem_done && mem_ok;
   assign timer_load = (state == ST_CLK_ARM);
   // First mark opens the window, expire closes it
   assign clk_mark   = (state == ST_CLK_ARM) || ((state == ST_CLK_RUN) && expire);

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state     <= ST_IDLE;
         fail_code <= RES_NONE;
         passed    <= 1'b0;
         fail_addr <= '0;
      end else begin
         case (state)
            ST_IDLE: begin
               // Results of the previous run are dropped here
               if (start) begin
                  state     <= ST_MEM;
                  fail_code <= RES_NONE;
                  passed    <= 1'b0;
                  fail_addr <= '0;
               end
            end
            ST_MEM: begin
               if (mem_done) begin
                  if (mem_ok) begin
                     state <= ST_CLK_ARM;
                  end else begin
                     // Memory fault, clock check skipped
                     fail_code <= RES_MEM;
                     fail_addr <= fail_addr_in;
                     state     <= ST_DONE;
                  end
               end
            end
            ST_CLK_ARM: state <= ST_CLK_RUN;
            ST_CLK_RUN: begin
               if (clk_done) begin
                  fail_code <= clk_ok ? RES_NONE : RES_CLK;
                  passed    <= clk_ok;
                  state     <= ST_DONE;
               end
            end
            default: state <= ST_IDLE;
         endcase
      end
   end

   assign status.busy      = (state != ST_IDLE) && (state != ST_DONE);
   assign status.done      = (state == ST_DONE);
   assign status.passed    = passed;
   assign status.fail_code = fail_code;
   assign status.fail_addr = fail_addr;

   // Checker results land only in the state waiting for them
   a_mem_done_in_mem: assert property (@(posedge clk) disable iff (!arst_n)
      mem_done |-> (state == ST_MEM));
   a_clk_done_in_run: assert property (@(posedge clk) disable iff (!arst_n)
      clk_done |-> (state == ST_CLK_RUN));

endmodule

/* hdl/selftest_top.sv */
/*
 * Power-on self-test top level
 * Sequencer, window timer, march checker and clock-ratio checker
 */
`timescale 1ns/10ps

module selftest_top
   import selftest_pkg::*;
(
   input  logic              clk,
   input  logic              fastclk,
   input  logic              arst_n,
   input  logic              start,
   input  logic [DATA_W-1:0] mem_rdata,
   output mem_req_t          mem_req,
   output selftest_status_t  status
);

   // Sequencer to checkers
   logic mem_start, clk_start, clk_mark, timer_load;
   // Checkers back to sequencer
   logic mem_done, mem_ok, clk_done, clk_ok, expire;
   logic [ADDR_W-1:0] fail_addr;

   selftest_seq i_seq (
      .clk, .arst_n, .start,
      .mem_done, .mem_ok, .clk_done, .clk_ok, .expire,
      .fail_addr_in (fail_addr),
      .mem_start, .clk_start, .clk_mark, .timer_load,
      .status
   );

   // Running flag only feeds the timer's own check
   cycle_timer i_timer (
      .clk, .arst_n,
      .load    (timer_load),
      .expire,
      .running ()
   );

   march_check i_march (
      .clk, .arst_n,
      .start (mem_start),
      .mem_req, .mem_rdata,
      .done  (mem_done),
      .ok    (mem_ok),
      .fail_addr
   );

   clk_ratio_check i_clk_ratio (
      .clk, .fastclk, .arst_n,
      .start (clk_start),
      .mark  (clk_mark),
      .done  (clk_done),
      .ok    (clk_ok)
   );

endmodule

/* sim/tb_selftest.sv */
/*
 * Testbench for the self-test block
 * Clocks, memory model with one stuck bit, expected-result model, checks
 */
`timescale 1ns/10ps

module tb_selftest
   import selftest_pkg::*;
();

   logic              clk;
   logic              fastclk;
   logic              arst_n;
   logic              start;
   logic [DATA_W-1:0] mem_rdata;
   mem_req_t          mem_req;
   selftest_status_t  status;

   // Memory image and the single stuck bit
   logic [DATA_W-1:0]         mem [MEM_WORDS];
   logic                      fault_en;
   logic [ADDR_W-1:0]         fault_addr;
   logic [$clog2(DATA_W)-1:0] fault_bit;
   logic                      fault_val;
   // fastclk at half its nominal rate
   logic                      fast_slow;

   int seed;
   int errors;
   int checks;
   int done_seen;
   int access_cnt;

   // clk 4 ns
   always #2 clk = ~clk;

   // fastclk 1 ns, or 2 ns when slowed
   always begin
      if (fast_slow) begin
         #1.0;
      end else begin
         #0.5;
      end
      fastclk = ~fastclk;
   end

   selftest_top i_selftest_top (
      .clk, .fastclk, .arst_n, .start, .mem_rdata, .mem_req, .status
   );

   function automatic logic [DATA_W-1:0] with_fault(input logic [ADDR_W-1:0] a,
                                                     input logic [DATA_W-1:0] d);
      logic [DATA_W-1:0] r;
      r = d;
      if (fault_en && (a == fault_addr)) begin
         r[fault_bit] = fault_val;
      end
      return r;
   endfunction

   // Synchronous memory, read data on the next edge
   always @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         mem_rdata <= '0;
      end else if (mem_req.en) begin
         access_cnt++;
         if (mem_req.we) begin
            mem[mem_req.addr] = with_fault(mem_req.addr, mem_req.wdata);
         end else begin
            mem_rdata <= with_fault(mem_req.addr, mem[mem_req.addr]);
         end
      end
   end

   // Done pulses, counted where status is stable
   always @(negedge clk) begin
      if (status.done) done_seen++;
   end

   task automatic check_val(input string name, input logic [31:0] exp,
                            input logic [31:0] act);
      checks++;
      if (exp !== act) begin
         errors++;
         $display("FAILED %s: expected 0x%0h, actual 0x%0h", name, exp, act);
      end
   endtask

   task automatic tick();
      @(posedge clk);
      #1;
   endtask

   // Expected outcome from the march and clock-ratio rules
   task automatic predict(output fail_code_e code, output logic pass,
                          output logic [ADDR_W-1:0] addr);
      addr = '0;
      if (fault_en) begin
         // Stuck-at-1 trips the read-0 of OP_R0W1_UP, stuck-at-0 the read-1
         // of OP_R1W0_DOWN, both at the faulty word itself
         code = RES_MEM;
         pass = 1'b0;
         addr = fault_addr;
      end else if (fast_slow) begin
         // About 128 edges, far below 256 minus the tolerance
         code = RES_CLK;
         pass = 1'b0;
      end else begin
         code = RES_NONE;
         pass = 1'b1;
      end
   endtask

   task automatic wait_done(input string name);
      int n;
      n = 0;
      while (!status.done && (n < 2000)) begin
         tick();
         n++;
      end
      if (!status.done) begin
         errors++;
         $display("Timeout: no done pulse within 2000 cycles in %s", name);
      end
   endtask

   task automatic inject_fault(input logic val);
      fault_en   = 1'b1;
      fault_addr = ADDR_W'({$random(seed)} % MEM_WORDS);
      fault_bit  = $bits(fault_bit)'({$random(seed)} % DATA_W);
      fault_val  = val;
   endtask

   // One accepted start, optional second start mid-run
   task automatic run_check(input string name, input logic poke_busy);
      fail_code_e        exp_code;
      logic              exp_pass;
      logic [ADDR_W-1:0] exp_addr;
      int                dones_before;
      int                accesses_before;
      predict(exp_code, exp_pass, exp_addr);
      dones_before    = done_seen;
      accesses_before = access_cnt;
      start = 1'b1;
      tick();
      start = 1'b0;
      check_val({name, " busy"}, 32'd1, 32'(status.busy));
      if (poke_busy) begin
         repeat (5) tick();
         start = 1'b1;
         tick();
         start = 1'b0;
      end
      wait_done(name);
      check_val({name, " passed"}, 32'(exp_pass), 32'(status.passed));
      check_val({name, " fail_code"}, 32'(exp_code), 32'(status.fail_code));
      if (exp_code == RES_MEM) begin
         check_val({name, " fail_addr"}, 32'(exp_addr), 32'(status.fail_addr));
      end else begin
         // Two one-pass elements and two read-then-write elements
         check_val({name, " accesses"}, 32'(6 * MEM_WORDS),
                   32'(access_cnt - accesses_before));
      end
      repeat (4) tick();
      // Exactly one done, results held in idle
      check_val({name, " done count"}, 32'd1, 32'(done_seen - dones_before));
      check_val({name, " idle"}, 32'd0, 32'(status.busy));
      check_val({name, " held code"}, 32'(exp_code), 32'(status.fail_code));
   endtask

   initial begin
      clk        = 1'b0;
      fastclk    = 1'b0;
      arst_n     = 1'b0;
      start      = 1'b0;
      fault_en   = 1'b0;
      fault_addr = '0;
      fault_bit  = '0;
      fault_val  = 1'b0;
      fast_slow  = 1'b0;
      seed       = 32'h3a73_4875;
      errors     = 0;
      checks     = 0;
      done_seen  = 0;
      access_cnt = 0;
      // Power-up contents, a different word at every address
      for (int i = 0; i < MEM_WORDS; i++) begin
         mem[ADDR_W'(i)] = DATA_W'(i * 29) ^ 8'h5a;
      end
      repeat (8) @(posedge clk);
      #1;
      arst_n = 1'b1;
      tick();

      check_val("reset busy", 32'd0, 32'(status.busy));
      check_val("reset done", 32'd0, 32'(status.done));
      check_val("reset passed", 32'd0, 32'(status.passed));
      check_val("reset mem en", 32'd0, 32'(mem_req.en));
      check_val("reset fail_code", 32'(RES_NONE), 32'(status.fail_code));

      run_check("clean", 1'b0);

      for (int n = 0; n < 20; n++) begin
         inject_fault(1'b1);
         run_check($sformatf("stuck1 run %0d", n), 1'b0);
      end
      for (int n = 0; n < 20; n++) begin
         inject_fault(1'b0);
         run_check($sformatf("stuck0 run %0d", n), 1'b0);
      end
      fault_en = 1'b0;

      // Slow fastclk, then back to nominal
      fast_slow = 1'b1;
      run_check("slow fastclk", 1'b0);
      fast_slow = 1'b0;
      run_check("fastclk restored", 1'b0);

      run_check("start while busy", 1'b1);

      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule

/* project.f */
hdl/selftest_pkg.sv
hdl/cycle_timer.sv
hdl/march_check.sv
hdl/clk_ratio_check.sv
hdl/selftest_seq.sv
hdl/selftest_top.sv
sim/tb_selftest.sv

/* Makefile */
TOP := tb_selftest

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module $(TOP) -f project.f

sim:
	verilator --binary --timing --top-module $(TOP) -f project.f
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^TEST RESULT: PASS$$"

clean:
	rm -rf obj_dir
